//--- design/rv_exec_pkg.sv
// Shared types and constants for the RV32I execute slice
// Word and register index types, opcodes, funct3 codes, execution kinds

`default_nettype none

package rv_exec_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [2:0]  funct3_t;

    // Major opcodes, insn[6:0]
    typedef enum logic [6:0] {
        op_lui    = 7'b0110111,
        op_auipc  = 7'b0010111,
        op_jal    = 7'b1101111,
        op_jalr   = 7'b1100111,
        op_branch = 7'b1100011,
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_arithi = 7'b0010011,
        op_arithr = 7'b0110011,
        op_fence  = 7'b0001111,
        op_system = 7'b1110011
    } opcode_e;

    // OP and OP-IMM funct3
    localparam funct3_t f3_add  = 3'd0;     // ADD/SUB
    localparam funct3_t f3_sll  = 3'd1;
    localparam funct3_t f3_slt  = 3'd2;
    localparam funct3_t f3_sltu = 3'd3;
    localparam funct3_t f3_xor  = 3'd4;
    localparam funct3_t f3_sr   = 3'd5;     // SRL/SRA
    localparam funct3_t f3_or   = 3'd6;
    localparam funct3_t f3_and  = 3'd7;

    // Branch funct3, 2 and 3 are reserved
    localparam funct3_t f3_beq  = 3'd0;
    localparam funct3_t f3_bne  = 3'd1;
    localparam funct3_t f3_blt  = 3'd4;
    localparam funct3_t f3_bge  = 3'd5;
    localparam funct3_t f3_bltu = 3'd6;
    localparam funct3_t f3_bgeu = 3'd7;

    typedef enum logic [2:0] {
        kind_alu,
        kind_lui,
        kind_auipc,
        kind_jal,
        kind_jalr,
        kind_branch,
        kind_illegal
    } exec_kind_e;

    localparam word_t pc_step = 32'd4;      // Fall-through increment

endpackage

`default_nettype wire

//--- design/rv_decode.sv
// Instruction decode stage
// Immediate generation, operand select and the decode pipeline register

`default_nettype none

module rv_decode (
    input  logic                    clk,
    input  logic                    resetb,
    input  logic                    in_valid,
    input  rv_exec_pkg::word_t      in_insn,
    input  rv_exec_pkg::word_t      in_pc,
    input  rv_exec_pkg::word_t      in_rs1_data,
    input  rv_exec_pkg::word_t      in_rs2_data,
    output logic                    d_valid,
    output rv_exec_pkg::exec_kind_e d_kind,
    output rv_exec_pkg::funct3_t    d_funct3,
    output logic                    d_sub,
    output rv_exec_pkg::word_t      d_op1,
    output rv_exec_pkg::word_t      d_op2,
    output rv_exec_pkg::word_t      d_imm,
    output rv_exec_pkg::word_t      d_pc,
    output rv_exec_pkg::reg_idx_t   d_rd
);
    import rv_exec_pkg::*;

    opcode_e    opcode;
    funct3_t    funct3;
    logic [6:0] funct7;
    word_t      imm;
    logic       imm_sel;
    logic       sub;
    exec_kind_e kind;

    assign opcode = opcode_e'(in_insn[6:0]);
    assign funct3 = in_insn[14:12];
    assign funct7 = in_insn[31:25];

    ////////////////////////////////////////////////////////////////////////////
    // Immediate and operation decode
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        case (opcode)
            op_lui, op_auipc: imm = {in_insn[31:12], 12'h0};
            op_jal:    imm = {{12{in_insn[31]}}, in_insn[19:12], in_insn[20],
                              in_insn[30:21], 1'b0};
            op_jalr:   imm = {{20{in_insn[31]}}, in_insn[31:20]};
            op_branch: imm = {{20{in_insn[31]}}, in_insn[7], in_insn[30:25],
                              in_insn[11:8], 1'b0};
            op_arithi: imm = (funct3 == f3_sll || funct3 == f3_sr) ?
                             {27'h0, in_insn[24:20]} :           // Shift amount
                             {{20{in_insn[31]}}, in_insn[31:20]};
            default:   imm = '0;
        endcase
    end

    assign imm_sel = (opcode == op_arithi) || (opcode == op_jalr);

    // SUB and SRA/SRAI only, ADDI keeps bit 30 as immediate
    assign sub = in_insn[30] &&
                 (((opcode == op_arithr) && (funct3 == f3_add || funct3 == f3_sr)) ||
                  ((opcode == op_arithi) && (funct3 == f3_sr)));

    always_comb begin
        case (opcode)
            op_lui:    kind = kind_lui;
            op_auipc:  kind = kind_auipc;
            op_jal:    kind = kind_jal;
            op_jalr:   kind = kind_jalr;
            op_branch: kind = kind_branch;
            op_arithi: kind = kind_alu;
            op_arithr: kind = (funct7 == 7'h00 || funct7 == 7'h20) ? kind_alu : kind_illegal;
            op_load, op_store, op_fence, op_system: kind = kind_illegal;  // Not executed here
            default:   kind = kind_illegal;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Pipeline register
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge resetb) begin
        if (!resetb) begin
            d_valid <= 1'b0;
            d_kind  <= kind_illegal;
        end else begin
            d_valid <= in_valid;
            if (in_valid) begin
                d_kind <= kind;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            d_funct3 <= funct3;
            d_sub    <= sub;
            d_op1    <= in_rs1_data;
            d_op2    <= imm_sel ? imm : in_rs2_data;
            d_imm    <= imm;
            d_pc     <= in_pc;
            d_rd     <= in_insn[11:7];
        end
    end

    a_insn_known: assert property (@(posedge clk) disable iff (!resetb)
        in_valid |-> !$isunknown(in_insn));

endmodule

`default_nettype wire

//--- design/rv_alu.sv
// Integer ALU for the execute stage
// RV32I arithmetic and logic, upper immediates and the jump link value

`default_nettype none

module rv_alu (
    input  rv_exec_pkg::exec_kind_e d_kind,
    input  rv_exec_pkg::funct3_t    d_funct3,
    input  logic                    d_sub,
    input  rv_exec_pkg::word_t      d_op1,
    input  rv_exec_pkg::word_t      d_op2,
    input  rv_exec_pkg::word_t      d_imm,
    input  rv_exec_pkg::word_t      d_pc,
    output rv_exec_pkg::word_t      alu_result
);
    import rv_exec_pkg::*;

    logic [32:0] diff_s;
    logic [32:0] diff_u;
    logic [4:0]  shamt;
    word_t       arith;

    // Sign of the 33-bit difference gives the compare
    assign diff_s = {d_op1[31], d_op1} - {d_op2[31], d_op2};
    assign diff_u = {1'b0, d_op1} - {1'b0, d_op2};
    assign shamt  = d_op2[4:0];

    always_comb begin
        case (d_funct3)
            f3_add:  arith = d_sub ? d_op1 - d_op2 : d_op1 + d_op2;
            f3_sll:  arith = d_op1 << shamt;
            f3_slt:  arith = {31'h0, diff_s[32]};
            f3_sltu: arith = {31'h0, diff_u[32]};
            f3_xor:  arith = d_op1 ^ d_op2;
            f3_sr: begin
                if (d_sub) begin
                    arith = word_t'($signed(d_op1) >>> shamt);    // SRA
                end else begin
                    arith = d_op1 >> shamt;
                end
            end
            f3_or:   arith = d_op1 | d_op2;
            f3_and:  arith = d_op1 & d_op2;
        endcase
    end

    always_comb begin
        case (d_kind)
            kind_alu:            alu_result = arith;
            kind_lui:            alu_result = d_imm;
            kind_auipc:          alu_result = d_pc + d_imm;
            kind_jal, kind_jalr: alu_result = d_pc + pc_step;   // Link
            default:             alu_result = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- design/rv_branch.sv
// Branch unit for the execute stage
// Branch compare, jump targets and next-PC select

`default_nettype none

module rv_branch (
    input  rv_exec_pkg::exec_kind_e d_kind,
    input  rv_exec_pkg::funct3_t    d_funct3,
    input  rv_exec_pkg::word_t      d_op1,
    input  rv_exec_pkg::word_t      d_op2,
    input  rv_exec_pkg::word_t      d_imm,
    input  rv_exec_pkg::word_t      d_pc,
    output rv_exec_pkg::word_t      next_pc,
    output logic                    bad_funct3
);
    import rv_exec_pkg::*;

    word_t taken_pc;
    word_t fall_pc;
    word_t jalr_sum;
    logic  cond;
    logic  cond_legal;

    assign taken_pc = d_pc + d_imm;
    assign fall_pc  = d_pc + pc_step;
    assign jalr_sum = d_op1 + d_imm;

    always_comb begin
        cond       = 1'b0;
        cond_legal = 1'b1;
        case (d_funct3)
            f3_beq:  cond = (d_op1 == d_op2);
            f3_bne:  cond = (d_op1 != d_op2);
            f3_blt:  cond = ($signed(d_op1) < $signed(d_op2));
            f3_bge:  cond = ($signed(d_op1) >= $signed(d_op2));
            f3_bltu: cond = (d_op1 < d_op2);
            f3_bgeu: cond = (d_op1 >= d_op2);
            default: cond_legal = 1'b0;     // funct3 2 and 3
        endcase
    end

    always_comb begin
        bad_funct3 = 1'b0;
        case (d_kind)
            kind_jal:    next_pc = taken_pc;
            kind_jalr:   next_pc = {jalr_sum[31:1], 1'b0};
            kind_branch: begin
                bad_funct3 = !cond_legal;
                next_pc    = cond ? taken_pc : fall_pc;
            end
            default:     next_pc = fall_pc;
        endcase
    end

endmodule

`default_nettype wire

//--- design/rv_retire.sv
// Retire stage
// Illegal detection, write-enable rules and the output register

`default_nettype none

module rv_retire (
    input  logic                    clk,
    input  logic                    resetb,
    input  logic                    d_valid,
    input  rv_exec_pkg::exec_kind_e d_kind,
    input  rv_exec_pkg::word_t      d_pc,
    input  rv_exec_pkg::reg_idx_t   d_rd,
    input  rv_exec_pkg::word_t      alu_result,
    input  rv_exec_pkg::word_t      next_pc,
    input  logic                    bad_funct3,
    output logic                    out_valid,
    output rv_exec_pkg::reg_idx_t   out_rd,
    output logic                    out_rd_we,
    output rv_exec_pkg::word_t      out_result,
    output rv_exec_pkg::word_t      out_next_pc,
    output logic                    out_illegal
);
    import rv_exec_pkg::*;

    logic illegal;
    logic rd_we;

    // Bit 1 of the target set means a misaligned fetch
    assign illegal = (d_kind == kind_illegal) || bad_funct3 || next_pc[1];
    assign rd_we   = !illegal && (d_kind != kind_branch) && (d_rd != '0);

    always_ff @(posedge clk or negedge resetb) begin
        if (!resetb) begin
            out_valid   <= 1'b0;
            out_rd      <= '0;
            out_rd_we   <= 1'b0;
            out_result  <= '0;
            out_next_pc <= '0;
            out_illegal <= 1'b0;
        end else begin
            out_valid <= d_valid;
            if (d_valid) begin                  // Held between strobes
                out_rd      <= d_rd;
                out_rd_we   <= rd_we;
                out_result  <= alu_result;
                out_next_pc <= illegal ? d_pc + pc_step : next_pc;
                out_illegal <= illegal;
            end
        end
    end

    a_illegal_no_write: assert property (@(posedge clk) disable iff (!resetb)
        !(out_illegal && out_rd_we));
    a_write_rd_nonzero: assert property (@(posedge clk) disable iff (!resetb)
        out_rd_we |-> (out_rd != '0));

endmodule

`default_nettype wire

//--- design/rv_exec_top.sv
// Top level of the RV32I execute slice
// Decode, ALU, branch unit and retire stage

`default_nettype none

module rv_exec_top (
    input  logic                  clk,
    input  logic                  resetb,
    input  logic                  in_valid,
    input  rv_exec_pkg::word_t    in_insn,
    input  rv_exec_pkg::word_t    in_pc,
    input  rv_exec_pkg::word_t    in_rs1_data,
    input  rv_exec_pkg::word_t    in_rs2_data,
    output logic                  out_valid,
    output rv_exec_pkg::reg_idx_t out_rd,
    output logic                  out_rd_we,
    output rv_exec_pkg::word_t    out_result,
    output rv_exec_pkg::word_t    out_next_pc,
    output logic                  out_illegal
);
    import rv_exec_pkg::*;

    logic       d_valid;
    exec_kind_e d_kind;
    funct3_t    d_funct3;
    logic       d_sub;
    word_t      d_op1;
    word_t      d_op2;
    word_t      d_imm;
    word_t      d_pc;
    reg_idx_t   d_rd;
    word_t      alu_result;
    word_t      next_pc;
    logic       bad_funct3;

    rv_decode i_decode (
        .clk, .resetb, .in_valid, .in_insn, .in_pc, .in_rs1_data, .in_rs2_data,
        .d_valid, .d_kind, .d_funct3, .d_sub, .d_op1, .d_op2, .d_imm, .d_pc, .d_rd
    );

    // ALU and branch unit share the decoded operands
    rv_alu i_alu (
        .d_kind, .d_funct3, .d_sub, .d_op1, .d_op2, .d_imm, .d_pc, .alu_result
    );

    rv_branch i_branch (
        .d_kind, .d_funct3, .d_op1, .d_op2, .d_imm, .d_pc, .next_pc, .bad_funct3
    );

    rv_retire i_retire (
        .clk, .resetb, .d_valid, .d_kind, .d_pc, .d_rd, .alu_result, .next_pc,
        .bad_funct3, .out_valid, .out_rd, .out_rd_we, .out_result, .out_next_pc,
        .out_illegal
    );

endmodule

`default_nettype wire

//--- dv/rv_ref_model.svh
// Reference model for the execute slice testbench
// Instruction encoders and the expected result, next PC and illegal flag

`ifndef RV_REF_MODEL_SVH
`define RV_REF_MODEL_SVH

// Source fields are fixed at x1 and x2, the data comes in on ports
function automatic word_t r_format(logic [6:0] f7, funct3_t f3, reg_idx_t rd, logic [6:0] op);
    return {f7, 5'd2, 5'd1, f3, rd, op};
endfunction

function automatic word_t i_format(logic [11:0] imm, funct3_t f3, reg_idx_t rd,
                                   logic [6:0] op);
    return {imm, 5'd1, f3, rd, op};
endfunction

function automatic word_t u_format(logic [19:0] imm, reg_idx_t rd, logic [6:0] op);
    return {imm, rd, op};
endfunction

function automatic word_t j_format(word_t off, reg_idx_t rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, op_jal};
endfunction

function automatic word_t b_format(word_t off, funct3_t f3);
    return {off[12], off[10:5], 5'd2, 5'd1, f3, off[4:1], off[11], op_branch};
endfunction

function automatic void predict(input word_t insn, input word_t pc, input word_t a,
                                input word_t b, output logic we, output word_t res,
                                output word_t npc, output logic ill);
    logic [6:0] op;
    funct3_t    f3;
    word_t      imm_i;
    word_t      rhs;
    logic       alt;
    logic       bad;
    logic       taken;
    logic       writes;
    op     = insn[6:0];
    f3     = insn[14:12];
    imm_i  = {{20{insn[31]}}, insn[31:20]};
    res    = '0;
    npc    = pc + 32'd4;
    rhs    = b;
    alt    = 1'b0;
    bad    = 1'b0;
    taken  = 1'b0;
    writes = 1'b1;
    case (op)
        op_lui:   res = {insn[31:12], 12'h0};
        op_auipc: res = pc + {insn[31:12], 12'h0};
        op_jal: begin
            res = pc + 32'd4;
            npc = pc + {{12{insn[31]}}, insn[19:12], insn[20], insn[30:21], 1'b0};
        end
        op_jalr: begin
            res = pc + 32'd4;
            npc = (a + imm_i) & ~32'h1;
        end
        op_branch: begin
            writes = 1'b0;
            case (f3)
                f3_beq:  taken = (a == b);
                f3_bne:  taken = (a != b);
                f3_blt:  taken = ($signed(a) < $signed(b));
                f3_bge:  taken = !($signed(a) < $signed(b));
                f3_bltu: taken = (a < b);
                f3_bgeu: taken = !(a < b);
                default: bad = 1'b1;
            endcase
            if (taken) begin
                npc = pc + {{20{insn[31]}}, insn[7], insn[30:25], insn[11:8], 1'b0};
            end
        end
        op_arithi, op_arithr: begin
            if (op == op_arithi) begin
                rhs = (f3 == f3_sll || f3 == f3_sr) ? {27'h0, insn[24:20]} : imm_i;
                alt = insn[30] && (f3 == f3_sr);
            end else begin
                bad = (insn[31:25] != 7'h00) && (insn[31:25] != 7'h20);
                alt = insn[30] && (f3 == f3_add || f3 == f3_sr);
            end
            case (f3)
                f3_add:  res = alt ? a - rhs : a + rhs;
                f3_sll:  res = a << rhs[4:0];
                f3_slt:  res = {31'h0, $signed(a) < $signed(rhs)};
                f3_sltu: res = {31'h0, a < rhs};
                f3_xor:  res = a ^ rhs;
                f3_sr: begin
                    if (alt) begin
                        res = word_t'($signed(a) >>> rhs[4:0]);
                    end else begin
                        res = a >> rhs[4:0];
                    end
                end
                f3_or:   res = a | rhs;
                default: res = a & rhs;
            endcase
            if (bad) begin
                res = '0;
            end
        end
        default: bad = 1'b1;
    endcase
    ill = bad || npc[1];                // Target off a 4-byte boundary
    if (ill) begin
        npc = pc + 32'd4;
    end
    we = !ill && writes && (insn[11:7] != 5'd0);
endfunction

`endif

//--- dv/tb_rv_exec.sv
// Testbench for the RV32I execute slice
// Directed tests checked against a queue of expected outputs

`default_nettype none

module tb_rv_exec;
    timeunit 1ns;
    timeprecision 1ps;

    import rv_exec_pkg::*;

    `include "rv_ref_model.svh"

    localparam int arith_rounds = 4;        // 20 instructions each
    localparam int jump_rounds  = 4;        // 4 instructions each
    localparam int branch_pairs = 4;        // Per condition
    localparam int illegal_cnt  = 14;
    localparam int stream_cnt   = 60;
    localparam int insn_total   = 20 * arith_rounds + 4 * jump_rounds + 6 * branch_pairs
                                  + illegal_cnt + stream_cnt;
    // Reset, idle check and a drain per test come on top
    localparam int max_cycles   = insn_total + 4 + 8 + 5 * 4 + 20;

    logic     clk;
    logic     resetb;
    logic     in_valid;
    word_t    in_insn;
    word_t    in_pc;
    word_t    in_rs1_data;
    word_t    in_rs2_data;
    logic     out_valid;
    reg_idx_t out_rd;
    logic     out_rd_we;
    word_t    out_result;
    word_t    out_next_pc;
    logic     out_illegal;
    int       cycle = 0;

    int       exp_due[$];                   // Cycle the output must show up in
    reg_idx_t exp_rd[$];
    logic     exp_we[$];
    word_t    exp_result[$];
    word_t    exp_next_pc[$];
    logic     exp_illegal[$];

    rv_exec_top i_dut (
        .clk, .resetb, .in_valid, .in_insn, .in_pc, .in_rs1_data, .in_rs2_data,
        .out_valid, .out_rd, .out_rd_we, .out_result, .out_next_pc, .out_illegal
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= max_cycles) begin
            stop_with_failure($sformatf("Timeout after %0d cycles with outputs missing", cycle));
        end
    end

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("Regression failed");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic check(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("Error: %s is 0x%08h, expected 0x%08h", name, got, exp));
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Drive and monitor
    ////////////////////////////////////////////////////////////////////////////
    task automatic issue_insn(input word_t insn, input word_t pc, input word_t a,
                              input word_t b);
        logic  we;
        logic  ill;
        word_t res;
        word_t npc;
        @(posedge clk);
        #1;
        in_valid    = 1'b1;
        in_insn     = insn;
        in_pc       = pc;
        in_rs1_data = a;
        in_rs2_data = b;
        predict(insn, pc, a, b, we, res, npc, ill);
        exp_due.push_back(cycle + 2);
        exp_rd.push_back(insn[11:7]);
        exp_we.push_back(we);
        exp_result.push_back(res);
        exp_next_pc.push_back(npc);
        exp_illegal.push_back(ill);
    endtask

    task automatic wait_for_drain();
        @(posedge clk);
        #1;
        in_valid = 1'b0;
        while (exp_due.size() != 0) begin
            @(posedge clk);
        end
    endtask

    always @(negedge clk) begin
        if (resetb && out_valid) begin
            if (exp_due.size() == 0) begin
                stop_with_failure("Output strobe seen with no instruction in flight");
            end else if (cycle != exp_due[0]) begin
                stop_with_failure($sformatf("Output came in cycle %0d instead of cycle %0d",
                                            cycle, exp_due[0]));
            end else begin
                void'(exp_due.pop_front());
                check("out_rd", 32'(out_rd), 32'(exp_rd.pop_front()));
                check("out_rd_we", 32'(out_rd_we), 32'(exp_we.pop_front()));
                check("out_result", out_result, exp_result.pop_front());
                check("out_next_pc", out_next_pc, exp_next_pc.pop_front());
                check("out_illegal", 32'(out_illegal), 32'(exp_illegal.pop_front()));
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Tests
    ////////////////////////////////////////////////////////////////////////////
    task automatic check_reset_state();
        repeat (8) begin
            @(negedge clk);
            check("out_valid", 32'(out_valid), 32'h0);
            check("out_rd", 32'(out_rd), 32'h0);
            check("out_rd_we", 32'(out_rd_we), 32'h0);
            check("out_illegal", 32'(out_illegal), 32'h0);
            check("out_result", out_result, 32'h0);
            check("out_next_pc", out_next_pc, 32'h0);
        end
    endtask

    // Eight funct3 ops plus SUB and SRA in register and immediate forms
    task automatic arith_ops();
        funct3_t     f3;
        logic [6:0]  f7;
        logic [11:0] imm;
        reg_idx_t    rd;
        for (int r = 0; r < arith_rounds; r++) begin
            for (int v = 0; v < 10; v++) begin
                f3 = (v < 8) ? funct3_t'(v) : ((v == 8) ? f3_add : f3_sr);
                f7 = (v < 8) ? 7'h00 : 7'h20;
                rd = (r == 0) ? 5'd0 : reg_idx_t'($urandom_range(31, 1));
                issue_insn(r_format(f7, f3, rd, op_arithr), $urandom() & 32'hffff_fffc,
                           $urandom(), $urandom());
                imm = 12'($urandom());
                if (f3 == f3_sll || f3 == f3_sr) begin
                    imm[11:5] = f7;
                end
                if (v == 8) begin
                    imm[10] = 1'b1;         // ADDI with bit 30 set stays an add
                end
                issue_insn(i_format(imm, f3, rd, op_arithi), $urandom() & 32'hffff_fffc,
                           $urandom(), $urandom());
            end
        end
    endtask

    task automatic upper_and_jumps();
        word_t       pc;
        word_t       a;
        word_t       off;
        logic [11:0] imm;
        for (int r = 0; r < jump_rounds; r++) begin
            pc   = $urandom() & 32'hffff_fffc;
            a    = $urandom();
            off  = $urandom();
            off  = {{11{off[20]}}, off[20:2], 2'b00};
            imm  = 12'($urandom());
            a[0] = ~imm[0];                 // Odd JALR sum so bit 0 must clear
            if (((a + {{20{imm[11]}}, imm}) & 32'h2) != 32'h0) begin
                a = a ^ 32'h2;
            end
            issue_insn(u_format(20'($urandom()), 5'd3, op_lui), pc, a, 32'h0);
            issue_insn(u_format(20'($urandom()), 5'd4, op_auipc), pc, a, 32'h0);
            issue_insn(j_format(off, 5'd1), pc, a, 32'h0);
            issue_insn(i_format(imm, 3'd0, 5'd5, op_jalr), pc, a, 32'h0);
        end
    endtask

    task automatic branch_conds();
        word_t a;
        word_t b;
        word_t off;
        for (int c = 0; c < 8; c++) begin
            if (c != 2 && c != 3) begin
                for (int p = 0; p < branch_pairs; p++) begin
                    a   = $urandom();
                    off = $urandom();
                    off = {{19{off[12]}}, off[12:2], 2'b00};
                    case (p)
                        0:       b = a;
                        1:       b = a ^ 32'h8000_0000;   // Signed and unsigned disagree
                        default: b = $urandom();
                    endcase
                    issue_insn(b_format(off, funct3_t'(c)), $urandom() & 32'hffff_fffc, a, b);
                end
            end
        end
    endtask

    task automatic illegal_insns();
        word_t pc;
        pc = 32'h0000_1000;
        issue_insn(i_format(12'h004, 3'd2, 5'd6, op_load), pc, 32'h100, 32'h0);
        issue_insn(i_format(12'h008, 3'd2, 5'd0, op_store), pc, 32'h100, 32'h55);
        issue_insn(i_format(12'h0ff, 3'd0, 5'd0, op_fence), pc, 32'h0, 32'h0);
        issue_insn(i_format(12'h000, 3'd0, 5'd0, op_system), pc, 32'h0, 32'h0);
        issue_insn(i_format(12'h123, 3'd0, 5'd7, 7'h00), pc, 32'h1, 32'h2);
        issue_insn(i_format(12'h123, 3'd0, 5'd7, 7'h7f), pc, 32'h1, 32'h2);
        issue_insn(r_format(7'h01, f3_add, 5'd8, op_arithr), pc, 32'h3, 32'h5);  // MUL
        issue_insn(r_format(7'h40, f3_add, 5'd8, op_arithr), pc, 32'h3, 32'h5);
        issue_insn(b_format(32'h10, 3'd2), pc, 32'h7, 32'h7);
        issue_insn(b_format(32'h10, 3'd3), pc, 32'h7, 32'h7);
        issue_insn(j_format(32'h6, 5'd1), pc, 32'h0, 32'h0);
        issue_insn(i_format(12'h002, 3'd0, 5'd1, op_jalr), pc, 32'h2000, 32'h0);
        issue_insn(i_format(12'h001, 3'd0, 5'd1, op_jalr), pc, 32'h2001, 32'h0);
        issue_insn(b_format(32'ha, f3_beq), pc, 32'h5, 32'h5);
    endtask

    task automatic back_to_back_stream();
        word_t       r;
        word_t       insn;
        funct3_t     f3;
        logic [11:0] imm;
        for (int n = 0; n < stream_cnt; n++) begin
            r   = $urandom();
            f3  = funct3_t'($urandom());
            imm = r[31:20];
            if (f3 == f3_sll || f3 == f3_sr) begin
                imm[11:5] = (f3 == f3_sr && r[0]) ? 7'h20 : 7'h00;
            end
            case ($urandom_range(4, 0))
                0: insn = r_format(((f3 == f3_add || f3 == f3_sr) && r[0]) ? 7'h20 : 7'h00,
                                   f3, r[11:7], op_arithr);
                1: insn = i_format(imm, f3, r[11:7], op_arithi);
                2: insn = u_format(r[31:12], r[11:7], r[5] ? op_lui : op_auipc);
                3: insn = j_format({{11{r[20]}}, r[20:2], 2'b00}, r[11:7]);
                default: insn = b_format({{19{r[12]}}, r[12:2], 2'b00},
                                         (f3 == 3'd2 || f3 == 3'd3) ? f3_beq : f3);
            endcase
            issue_insn(insn, $urandom() & 32'hffff_fffc, $urandom(), $urandom());
        end
    endtask

    initial begin
        void'($urandom(97));
        clk         = 1'b0;
        resetb      = 1'b0;
        in_valid    = 1'b0;
        in_insn     = '0;
        in_pc       = '0;
        in_rs1_data = '0;
        in_rs2_data = '0;
        repeat (4) @(posedge clk);
        #1;
        resetb = 1'b1;
        check_reset_state();
        arith_ops();
        wait_for_drain();
        upper_and_jumps();
        wait_for_drain();
        branch_conds();
        wait_for_drain();
        illegal_insns();
        wait_for_drain();
        back_to_back_stream();
        wait_for_drain();
        $display("Regression passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
+incdir+dv
design/rv_exec_pkg.sv
design/rv_decode.sv
design/rv_alu.sv
design/rv_branch.sv
design/rv_retire.sv
design/rv_exec_top.sv
dv/tb_rv_exec.sv

//--- run.sh
#!/bin/sh
verilator --binary --timing --assert --timescale 1ns/1ps -f list.f \
    --top-module tb_rv_exec -o sim_rv_exec \
    && ./obj_dir/sim_rv_exec \
    || exit 1
